/* design/gsim_num_pkg.sv */
package gsim_num_pkg;

    // sizes of the problem and the fixed-point format
    localparam int N_UNKNOWNS  = 16;  // unknowns per system
    localparam int B_FRAC_BITS = 16;  // b sits at the integer position of x

    // right-hand value as it arrives on b_in
    typedef logic signed [15:0] b_word_t;

    // unknown, 16 integer and 16 fraction bits
    typedef logic signed [31:0] x_word_t;

    // weighted sum before the divide, wide enough for 13*(x+x) plus b
    typedef logic signed [36:0] acc_t;

    // neighbours of the unknown being updated, zero outside 1..16
    typedef struct packed {
        x_word_t xm1;  // x[i-1]
        x_word_t xp1;  // x[i+1]
        x_word_t xm2;  // x[i-2]
        x_word_t xp2;  // x[i+2]
        x_word_t xm3;  // x[i-3]
        x_word_t xp3;  // x[i+3]
    } x_window_t;

endpackage

/* design/gsim_ctrl_pkg.sv */
package gsim_ctrl_pkg;

    // index into the register files, 0 is x[1]
    typedef logic [3:0] idx_t;

    // counts finished sweeps
    typedef logic [9:0] iter_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,   // waiting for the first in_en
        LOAD,   // taking b values
        SWEEP,  // gauss-seidel updates
        OUT     // streaming x out
    } gsim_state_t;

    // strobes and address from the sequencer to both register files
    typedef struct packed {
        idx_t idx;    // entry being written or read
        logic b_wr;   // store b_in at idx
        logic x_clr;  // zero every x
        logic x_wr;   // store the new x at idx
    } sweep_ctl_t;

endpackage

/* design/b_store.sv */
`timescale 1ns/1ps
module b_store (
    input  logic                      clk_in,
    input  gsim_ctrl_pkg::sweep_ctl_t ctl,
    input  gsim_num_pkg::b_word_t     b_in,
    output gsim_num_pkg::b_word_t     b_sel
);
    import gsim_num_pkg::*;

    b_word_t b_r [N_UNKNOWNS];  // b[1..16] at 0..15

    // load path, one value per in_en cycle
    always_ff @(posedge clk_in) begin
        if (ctl.b_wr) begin
            b_r[ctl.idx] <= b_in;
        end
    end

    assign b_sel = b_r[ctl.idx];  // same address as the update slot

endmodule

/* design/x_store.sv */
`timescale 1ns/1ps
module x_store (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  gsim_ctrl_pkg::sweep_ctl_t ctl,
    input  gsim_num_pkg::x_word_t     x_new,
    output gsim_num_pkg::x_window_t   window,
    output gsim_num_pkg::x_word_t     x_sel
);
    import gsim_num_pkg::*;

    localparam int PAD = 3;  // reach of the band on each side

    x_word_t x_r   [N_UNKNOWNS];            // x[1..16] at 0..15
    x_word_t x_pad [N_UNKNOWNS + 2 * PAD];  // zeros around x_r
    int      base;                          // x_pad slot of x[idx]

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            for (int i = 0; i < N_UNKNOWNS; i++) begin
                x_r[i] <= '0;
            end
        end else if (ctl.x_clr) begin  // start of a new load
            for (int i = 0; i < N_UNKNOWNS; i++) begin
                x_r[i] <= '0;
            end
        end else if (ctl.x_wr) begin
            x_r[ctl.idx] <= x_new;  // newest value seen by the next slot
        end
    end

    // neighbours past either end read as zero
    always_comb begin
        for (int i = 0; i < N_UNKNOWNS + 2 * PAD; i++) begin
            x_pad[i] = '0;
        end
        for (int i = 0; i < N_UNKNOWNS; i++) begin
            x_pad[i + PAD] = x_r[i];
        end
    end

    assign base = int'(ctl.idx) + PAD;

    always_comb begin
        window.xm1 = x_pad[base - 1];
        window.xp1 = x_pad[base + 1];
        window.xm2 = x_pad[base - 2];
        window.xp2 = x_pad[base + 2];
        window.xm3 = x_pad[base - 3];
        window.xp3 = x_pad[base + 3];
    end

    assign x_sel = x_r[ctl.idx];  // output stream read

endmodule

/* design/gs_update.sv */
`timescale 1ns/1ps
module gs_update (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  gsim_num_pkg::x_window_t window,
    input  gsim_num_pkg::b_word_t   b_sel,
    output gsim_num_pkg::acc_t      acc
);
    import gsim_num_pkg::*;

    acc_t b_term;   // b in x format
    acc_t s1;       // pair at distance 1
    acc_t s2;       // pair at distance 2
    acc_t s3;       // pair at distance 3
    acc_t mul13;
    acc_t mul6;
    acc_t acc_nxt;

    assign b_term = acc_t'(b_sel) <<< B_FRAC_BITS;  // sign kept by the cast

    assign s1 = acc_t'(window.xm1) + acc_t'(window.xp1);
    assign s2 = acc_t'(window.xm2) + acc_t'(window.xp2);
    assign s3 = acc_t'(window.xm3) + acc_t'(window.xp3);

    assign mul13 = s1 + (s1 <<< 2) + (s1 <<< 3);  // 1 + 4 + 8
    assign mul6  = (s2 <<< 1) + (s2 <<< 2);       // 2 + 4

    assign acc_nxt = b_term + mul13 - mul6 + s3;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            acc <= '0;
        end else begin
            acc <= acc_nxt;  // taken at the end of phase 0
        end
    end

endmodule

/* design/div20_approx.sv */
`timescale 1ns/1ps
module div20_approx (
    input  gsim_num_pkg::acc_t    acc,
    output gsim_num_pkg::x_word_t x_new
);
    import gsim_num_pkg::*;

    acc_t p_hi;  // weights 2^-5 down to 2^-18
    acc_t p_lo;  // weights 2^-21 down to 2^-30

    // 1/20 ~ 2^-5 * (1 + 2^-1)(1 + 2^-4 + 2^-8 + ...)
    assign p_hi = acc
                + (acc >>> 1)
                + (acc >>> 4)
                + (acc >>> 5)
                + (acc >>> 8)
                + (acc >>> 9)
                + (acc >>> 12)
                + (acc >>> 13);

    // tail of the series, kept apart to hold its own truncation
    assign p_lo = (acc >>> 16)
                + (acc >>> 17)
                + (acc >>> 20)
                + (acc >>> 21)
                + (acc >>> 24)
                + (acc >>> 25);

    // final 2^-5 scale, each half truncated to the x word
    assign x_new = x_word_t'(p_hi >>> 5) + x_word_t'(p_lo >>> 5);

endmodule

/* design/gsim_ctrl.sv */
`timescale 1ns/1ps
module gsim_ctrl #(
    parameter int ITERATIONS = 100  // sweeps before output
) (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      in_en,
    output gsim_ctrl_pkg::sweep_ctl_t ctl,
    output logic                      out_valid
);
    import gsim_ctrl_pkg::*;

    gsim_state_t state;
    idx_t        idx;        // current unknown
    logic        phase;      // 0 reads the window, 1 writes x
    iter_t       iter;       // finished sweeps
    logic        last_idx;
    logic        last_iter;

    assign last_idx  = (idx == '1);                        // x[16]
    assign last_iter = (iter == iter_t'(ITERATIONS - 1));  // final sweep

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state <= IDLE;
            idx   <= '0;
            phase <= 1'b0;
            iter  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_en) begin              // b[1] written this cycle
                        state <= LOAD;
                        idx   <= idx + 1'b1;
                    end
                end
                LOAD: begin
                    if (in_en) begin
                        idx <= idx + 1'b1;        // wraps to 0 after b[16]
                    end else begin                // one spare cycle, then sweep
                        state <= SWEEP;
                        idx   <= '0;
                        phase <= 1'b0;
                        iter  <= '0;
                    end
                end
                SWEEP: begin
                    phase <= ~phase;
                    if (phase) begin              // slot done, next unknown
                        idx <= idx + 1'b1;
                        if (last_idx) begin
                            if (last_iter) begin
                                state <= OUT;     // idx wraps to 0 for x[1]
                            end else begin
                                iter <= iter + 1'b1;
                            end
                        end
                    end
                end
                OUT: begin
                    idx <= idx + 1'b1;
                    if (last_idx) begin
                        state <= IDLE;            // idx back at 0
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_comb begin
        ctl.idx   = idx;
        ctl.b_wr  = in_en && ((state == IDLE) || (state == LOAD));
        ctl.x_clr = in_en && (state == IDLE);  // fresh start for each problem
        ctl.x_wr  = (state == SWEEP) && phase;  // acc holds phase 0 sum
    end

    assign out_valid = (state == OUT);  // x_out follows idx

endmodule

/* design/gsim_top.sv */
`timescale 1ns/1ps
module gsim_top #(
    parameter int ITERATIONS = 100  // sweeps per problem
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  in_en,
    input  gsim_num_pkg::b_word_t b_in,
    output logic                  out_valid,
    output gsim_num_pkg::x_word_t x_out
);
    import gsim_num_pkg::*;
    import gsim_ctrl_pkg::*;

    sweep_ctl_t ctl;     // shared address and strobes
    x_window_t  window;  // neighbours of x[idx]
    b_word_t    b_sel;   // b[idx]
    acc_t       acc;     // registered weighted sum
    x_word_t    x_new;   // divided result, written back in phase 1

    gsim_ctrl #(
        .ITERATIONS(ITERATIONS)
    ) u_ctrl (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .in_en    (in_en),
        .ctl      (ctl),
        .out_valid(out_valid)
    );

    b_store u_b_store (
        .clk_in(clk_in),
        .ctl   (ctl),
        .b_in  (b_in),
        .b_sel (b_sel)
    );

    x_store u_x_store (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .ctl   (ctl),
        .x_new (x_new),
        .window(window),
        .x_sel (x_out)      // read port doubles as the output stream
    );

    gs_update u_gs_update (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .window(window),
        .b_sel (b_sel),
        .acc   (acc)
    );

    div20_approx u_div20 (
        .acc  (acc),
        .x_new(x_new)
    );

endmodule

/* sim/tb_gsim.sv */
`timescale 1ns/1ps
module tb_gsim;
    import gsim_num_pkg::*;

    localparam int ITERATIONS   = 8;     // sweeps per problem in the DUT
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;     // inputs change this long after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int N_PROBLEMS   = 2;
    localparam int MAX_GAP      = 7;     // largest 3-bit idle gap
    localparam int LATENCY      = 32 * ITERATIONS + 2;  // last in_en to first out_valid
    localparam int WAIT_LIMIT   = LATENCY + 40;         // bound on one out_valid wait
    localparam int RUN_CYCLES   = 2 * N_UNKNOWNS + LATENCY + MAX_GAP + 4;
    localparam int N_RUNS       = 4;     // two problems plus the aborted run and the rerun
    localparam int WATCHDOG_CYCLES = N_RUNS * RUN_CYCLES + 2 * RESET_CYCLES
                                   + LATENCY + 40;
    localparam logic [31:0] HI_SHIFTS = 32'h0000_3333;  // shifts 0 1 4 5 8 9 12 13
    localparam logic [31:0] LO_SHIFTS = 32'h0333_0000;  // shifts 16 17 20 21 24 25
    localparam logic [15:0] LFSR_SEED = 16'd21048;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;       // x^16 + x^14 + x^13 + x^11 + 1

    logic    clk_in;
    logic    rst_in;
    logic    in_en;
    b_word_t b_in;
    logic    out_valid;
    x_word_t x_out;

    logic [15:0] test_mem [0:N_PROBLEMS * N_UNKNOWNS - 1];  // b values of both problems in order
    int          exp_x [0:N_UNKNOWNS - 1];                 // model result for x[1..16]
    logic [15:0] lfsr_state;
    logic        outputs_allowed;  // high while an output stream may legally appear
    int          check_count;
    int          value_errors;
    int          other_errors;

    gsim_top #(
        .ITERATIONS(ITERATIONS)
    ) u_dut (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .in_en    (in_en),
        .b_in     (b_in),
        .out_valid(out_valid),
        .x_out    (x_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // hard stop in case the DUT never answers
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // out_valid must stay low outside an output window
    always @(negedge clk_in) begin
        if (!outputs_allowed && out_valid !== 1'b0) begin
            check_val("out_valid", out_valid, 1'b0);
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            value = (value << 1) | lfsr_state[0];  // one step per bit taken
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // shift-and-add 1/20 with two partial sums each scaled and cut to 32 bits
    function automatic int div20_model(input longint a);
        longint sum_hi;
        longint sum_lo;
        int     part_hi;
        int     part_lo;
        sum_hi = 0;
        sum_lo = 0;
        for (int s = 0; s < 32; s++) begin
            if (HI_SHIFTS[s]) begin
                sum_hi = sum_hi + (a >>> s);
            end
            if (LO_SHIFTS[s]) begin
                sum_lo = sum_lo + (a >>> s);
            end
        end
        part_hi = sum_hi >>> 5;  // low 32 bits kept
        part_lo = sum_lo >>> 5;
        return part_hi + part_lo;
    endfunction

    // gauss-seidel sweeps from x = 0 in index order using the newest values
    task automatic compute_expected(input int problem);
        int     xs [0:N_UNKNOWNS + 5];  // x[i] at i + 2 with zeros beyond the band
        longint acc;
        longint near_sum;
        longint mid_sum;
        longint far_sum;
        longint b_val;
        int     j;
        for (int k = 0; k < N_UNKNOWNS + 6; k++) begin
            xs[k] = 0;
        end
        for (int it = 0; it < ITERATIONS; it++) begin
            for (int i = 1; i <= N_UNKNOWNS; i++) begin
                j = i + 2;
                b_val = $signed(test_mem[problem * N_UNKNOWNS + i - 1]);
                near_sum = xs[j - 1];
                near_sum = near_sum + xs[j + 1];
                mid_sum = xs[j - 2];
                mid_sum = mid_sum + xs[j + 2];
                far_sum = xs[j - 3];
                far_sum = far_sum + xs[j + 3];
                acc = (b_val <<< B_FRAC_BITS) + 13 * near_sum - 6 * mid_sum + far_sum;
                acc = (acc <<< 27) >>> 27;  // 37-bit accumulator
                xs[j] = div20_model(acc);
            end
        end
        for (int i = 0; i < N_UNKNOWNS; i++) begin
            exp_x[i] = xs[i + 3];
        end
    endtask

    task automatic load_problem(input int problem);
        for (int i = 0; i < N_UNKNOWNS; i++) begin
            @(posedge clk_in);
            #DRIVE_DELAY;
            in_en = 1'b1;
            b_in  = test_mem[problem * N_UNKNOWNS + i];  // b[1] first
        end
        @(posedge clk_in);
        #DRIVE_DELAY;
        in_en = 1'b0;
        b_in  = '0;
    endtask

    task automatic collect_outputs(input int problem);
        int waited;
        waited = 0;
        @(negedge clk_in);
        while (out_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk_in);
            waited++;
        end
        if (out_valid !== 1'b1) begin
            other_errors++;
            $display("no output stream for problem %0d within %0d cycles",
                     problem + 1, WAIT_LIMIT);
        end else begin
            for (int k = 0; k < N_UNKNOWNS; k++) begin
                if (k > 0) begin
                    @(negedge clk_in);
                    check_val("out_valid", out_valid, 1'b1);  // no gap inside the stream
                end
                check_val($sformatf("x_out[%0d]", k + 1), x_out, exp_x[k]);
            end
            @(negedge clk_in);
            check_val("out_valid", out_valid, 1'b0);  // no 17th word
        end
        @(posedge clk_in);
    endtask

    task automatic idle_gap();
        int gap;
        random_bits(3, gap);
        repeat (gap) @(posedge clk_in);
    endtask

    task automatic run_problem(input int problem);
        compute_expected(problem);
        load_problem(problem);
        outputs_allowed = 1'b1;
        collect_outputs(problem);
        outputs_allowed = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b0;
    endtask

    initial begin
        rst_in          = 1'b1;
        in_en           = 1'b0;
        b_in            = '0;
        outputs_allowed = 1'b0;
        lfsr_state      = LFSR_SEED;
        check_count     = 0;
        value_errors    = 0;
        other_errors    = 0;
        $readmemh("sim/gsim_tests.txt", test_mem);
        for (int k = 0; k < N_PROBLEMS * N_UNKNOWNS; k++) begin
            if (^test_mem[k] === 1'bx) begin
                other_errors++;
                $display("test data entry %0d is missing or unreadable", k);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b0;

        run_problem(0);  // first problem straight after reset
        idle_gap();
        run_problem(1);  // must start from cleared x

        idle_gap();
        load_problem(0);                        // third run that gets cut short
        repeat (LATENCY / 2) @(posedge clk_in);  // midway through the sweeps
        apply_reset();
        repeat (LATENCY) @(posedge clk_in);     // past where its output would have been

        idle_gap();
        run_problem(0);  // same answers as the first run

        $display("checks: %0d  value errors: %0d  other errors: %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim/gsim_tests.txt */
// one b value per line, 16-bit two's complement hex, b[1] first
// lines 1-16 are problem 1, lines 17-32 are problem 2
0100
0280
FF00
0040
03E8
FC18
0001
0000
07D0
F830
0123
FEDC
0055
00AA
FF80
0200
0064
FF9C
00C8
FF38
012C
FED4
0190
FE70
01F4
FE0C
0258
FDA8
02BC
FD44
0320
FCE0

/* flist.f */
design/gsim_num_pkg.sv
design/gsim_ctrl_pkg.sv
design/b_store.sv
design/x_store.sv
design/gs_update.sv
design/div20_approx.sv
design/gsim_ctrl.sv
design/gsim_top.sv
sim/tb_gsim.sv
